//--- dv/pu_spi_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "pu_spi_config.svh"

module pu_spi_checker
    import pu_spi_pkg::*;
(
    input logic                      clk,
    input logic                      rst,
    input logic                      cs,
    input logic                      sclk,
    input logic                      miso,
    input logic                      signal_oe,
    input logic                      flag_start,
    input logic                      flag_stop,
    input logic [`PU_DATA_WIDTH-1:0] data_out,
    input logic [`PU_ATTR_WIDTH-1:0] attr_out
);

    // Filled by the testbench top
    logic [31:0] exp_miso[$];
    logic [31:0] exp_rx[$];
    int          errors       = 0;
    int          miso_checked = 0;
    int          rx_checked   = 0;

    logic        cs_q;
    logic        sclk_q;
    logic        fin_m;
    logic        want_empty;
    logic [31:0] shift;
    int          bits;
    int          start_due;
    int          stop_due;

    task automatic log_error(input string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task automatic compare_miso_word(input logic [31:0] got);
        logic [31:0] want;
        if (exp_miso.size() == 0) begin
            errors++;
            $display("Checker: a miso word arrived when none was expected");
        end else begin
            want = exp_miso.pop_front();
            miso_checked++;
            if (got !== want) begin
                log_error($sformatf("miso word %h, expected %h", got, want));
            end
        end
    endtask

    task automatic take_rx_word();
        logic [31:0] want;
        logic        want_full;
        if (exp_rx.size() == 0) begin
            errors++;
            $display("Checker: signal_oe read a word when none was expected");
        end else begin
            // Every pending word sits in the receive buffer before a read
            want_full = (exp_rx.size() >= `PU_BUF_SIZE);
            want = exp_rx.pop_front();
            rx_checked++;
            if (data_out !== want) begin
                log_error($sformatf("data_out %h, expected %h", data_out, want));
            end
            if (!attr_out[VALID]) begin
                log_error("attr_out VALID clear during a read");
            end
            if (attr_out[FULL] !== want_full) begin
                log_error($sformatf("attr_out FULL %b, expected %b",
                                    attr_out[FULL], want_full));
            end
            want_empty = (exp_rx.size() == 0);
        end
    endtask

    task automatic report_leftovers();
        if (exp_miso.size() != 0) begin
            errors++;
            $display("Checker: %0d expected miso words were never seen", exp_miso.size());
        end
        if (exp_rx.size() != 0) begin
            errors++;
            $display("Checker: %0d received words were never read", exp_rx.size());
        end
        if (start_due != 0 || stop_due != 0) begin
            errors++;
            $display("Checker: missing flag pulses, %0d start and %0d stop", start_due, stop_due);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            cs_q       = 1'b1;
            sclk_q     = 1'b0;
            fin_m      = 1'b0;
            want_empty = 1'b0;
            shift      = '0;
            bits       = 0;
            start_due  = 0;
            stop_due   = 0;
        end else begin
            // Frame edges
            if (cs_q && !cs) begin
                bits = 0;
                start_due++;
            end
            if (!cs_q && cs) begin
                stop_due++;
                if (bits != 0) begin
                    errors++;
                    $display("Checker: transaction ended %0d bits into a word", bits);
                end
            end
            // Master view of miso, taken on sclk rise
            if (!cs && sclk && !sclk_q) begin
                shift = {shift[30:0], miso};
                bits++;
                if (bits == 32) begin
                    bits = 0;
                    compare_miso_word(shift);
                end
            end
            if (flag_start) begin
                if (start_due == 0) begin
                    log_error("flag_start without a cs fall");
                end else begin
                    start_due--;
                end
            end
            if (flag_stop) begin
                if (stop_due == 0) begin
                    log_error("flag_stop without a cs rise");
                end else begin
                    stop_due--;
                end
            end
            if (attr_out[SPI_FINISH] !== fin_m) begin
                log_error($sformatf("attr_out SPI_FINISH %b, expected %b",
                                    attr_out[SPI_FINISH], fin_m));
            end
            fin_m = flag_stop ? 1'b1 : (signal_oe ? 1'b0 : fin_m);
            if (want_empty) begin
                want_empty = 1'b0;
                if (!attr_out[INVALID]) begin
                    log_error("attr_out INVALID clear after the last read");
                end
            end
            if (signal_oe) begin
                take_rx_word();
            end
            cs_q   = cs;
            sclk_q = sclk;
        end
    end

endmodule

`default_nettype wire

//--- dv/spi_input.txt
# Columns: W <hex word> system write | C bank swap pulse | R read all received
# T <n> <n hex mosi words> one SPI transaction of n words
W 00a1b2c3
W 11223344
W 55667788
C
T 3 cafef00d 01020304 a5a55a5a
R
T 2 deadbeef 10203040
R
W 0012abcd
W 9abcdef0
C
W 00fedcba
C
T 3 13579bdf 2468ace0 0f0f0f0f
R
C
T 1 77665544
R
W 00000011
W 22000022
W 33000033
W 44000044
W 55000055
W 66000066
W 77000077
W 88000088
C
T 6 f0000001 f0000002 f0000003 f0000004 f0000005 f0000006
R
T 1 12345678
R

//--- dv/tb_pu_slave_spi.sv
`timescale 1ns/1ns
`default_nettype none

`include "pu_spi_config.svh"

module tb_pu_slave_spi
    import pu_spi_pkg::*;
();

    logic                      clk;
    logic                      rst;
    logic                      signal_cycle;
    logic                      signal_wr;
    logic [`PU_DATA_WIDTH-1:0] data_in;
    logic                      signal_oe;
    logic [`PU_DATA_WIDTH-1:0] data_out;
    logic [`PU_ATTR_WIDTH-1:0] attr_out;
    logic                      flag_start;
    logic                      flag_stop;
    logic                      mosi;
    logic                      miso;
    logic                      sclk;
    logic                      cs;

    // Parsed commands, arguments and the reference bank model
    byte         cmd_q[$];
    logic [31:0] arg_q[$];
    logic [31:0] tx_words[$];
    logic [31:0] fill_q[$];
    logic [31:0] drain_q[$];
    int          lines;
    int          total_words;
    int          limit;
    int          cycles;

    pu_slave_spi DUT (
        .clk          (clk),
        .rst          (rst),
        .signal_cycle (signal_cycle),
        .signal_wr    (signal_wr),
        .data_in      (data_in),
        .signal_oe    (signal_oe),
        .data_out     (data_out),
        .attr_out     (attr_out),
        .flag_start   (flag_start),
        .flag_stop    (flag_stop),
        .mosi         (mosi),
        .miso         (miso),
        .sclk         (sclk),
        .cs           (cs)
    );

    pu_spi_checker chk (
        .clk        (clk),
        .rst        (rst),
        .cs         (cs),
        .sclk       (sclk),
        .miso       (miso),
        .signal_oe  (signal_oe),
        .flag_start (flag_start),
        .flag_stop  (flag_stop),
        .data_out   (data_out),
        .attr_out   (attr_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------------------------------------------------------------
    // Run limit
    // --------------------------------------------------------------------------
    initial begin
        cycles = 0;
        while (limit == 0 || cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d clock cycles", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic load_commands(input int fd);
        string                tok;
        logic [8*128-1:0]     rest;
        logic [31:0]          value;
        int                   code;
        int                   n;
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %s", tok);
            if (code == 1) begin
                if (tok.substr(0, 0) == "#") begin
                    code = $fgets(rest, fd);
                end else if (tok == "W") begin
                    code = $fscanf(fd, " %h", value);
                    cmd_q.push_back("W");
                    arg_q.push_back(value);
                    lines++;
                    total_words++;
                end else if (tok == "T") begin
                    code = $fscanf(fd, " %d", n);
                    cmd_q.push_back("T");
                    arg_q.push_back(32'(n));
                    for (int i = 0; i < n; i++) begin
                        code = $fscanf(fd, " %h", value);
                        arg_q.push_back(value);
                    end
                    lines++;
                    total_words += n;
                end else begin
                    cmd_q.push_back(tok == "C" ? "C" : "R");
                    lines++;
                end
            end
        end
    endtask

    // Full bank drops the write
    task automatic write_word(input logic [31:0] w);
        if (fill_q.size() < `PU_BUF_SIZE) begin
            fill_q.push_back(w);
        end
        signal_wr = 1'b1;
        data_in   = w;
        @(negedge clk);
        signal_wr = 1'b0;
        @(negedge clk);
    endtask

    // Swap only when fill holds data and drain is empty
    task automatic pulse_cycle();
        if (fill_q.size() != 0 && drain_q.size() == 0) begin
            drain_q = fill_q;
            fill_q.delete();
        end
        signal_cycle = 1'b1;
        @(negedge clk);
        signal_cycle = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    // Mode 0 master, sclk toggles every 8 clk
    task automatic spi_transfer();
        foreach (tx_words[i]) begin
            if (drain_q.size() != 0) begin
                chk.exp_miso.push_back(drain_q.pop_front());
            end else begin
                chk.exp_miso.push_back(32'h0);
            end
            chk.exp_rx.push_back(tx_words[i]);
        end
        cs = 1'b0;
        repeat (16) @(negedge clk);
        foreach (tx_words[i]) begin
            for (int b = 31; b >= 0; b--) begin
                mosi = tx_words[i][b];
                repeat (8) @(negedge clk);
                sclk = 1'b1;
                repeat (8) @(negedge clk);
                sclk = 0;
            end
        end
        repeat (8) @(negedge clk);
        cs   = 1'b1;
        mosi = 1'b0;
        repeat (16) @(negedge clk);
    endtask

    // One read strobe per word the master has sent since the last read
    task automatic read_all();
        int n;
        n = chk.exp_rx.size();
        for (int i = 0; i < n; i++) begin
            signal_oe = 1'b1;
            @(negedge clk);
        end
        signal_oe = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        int fd;
        int ai;
        int n;
        rst          = 1'b1;
        signal_cycle = 1'b0;
        signal_wr    = 1'b0;
        data_in      = '0;
        signal_oe    = 1'b0;
        mosi         = 1'b0;
        sclk         = 1'b0;
        cs           = 1'b1;
        lines        = 0;
        total_words  = 0;
        limit        = 0;
        ai           = 0;
        fd = $fopen("dv/spi_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file dv/spi_input.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            load_commands(fd);
            $fclose(fd);
            limit = total_words * 32 * 16 + 200 * lines + 1000;
            repeat (4) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            repeat (2) @(negedge clk);
            foreach (cmd_q[i]) begin
                case (cmd_q[i])
                    "W": begin
                        write_word(arg_q[ai]);
                        ai++;
                    end
                    "C": pulse_cycle();
                    "T": begin
                        n = int'(arg_q[ai]);
                        ai++;
                        tx_words.delete();
                        for (int k = 0; k < n; k++) begin
                            tx_words.push_back(arg_q[ai]);
                            ai++;
                        end
                        spi_transfer();
                    end
                    default: read_all();
                endcase
            end
            repeat (10) @(negedge clk);
            chk.report_leftovers();
            $display("Errors: %0d, miso words checked: %0d, received words checked: %0d",
                     chk.errors, chk.miso_checked, chk.rx_checked);
            if (chk.errors == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hdl
hdl/pu_spi_pkg.sv
hdl/pu_spi_if.sv
hdl/spi_slave_driver.sv
hdl/spi_buffer.sv
hdl/hoarder.sv
hdl/byte_collector.sv
hdl/spi_bank_control.sv
hdl/pu_slave_spi.sv
dv/pu_spi_checker.sv
dv/tb_pu_slave_spi.sv

//--- hdl/byte_collector.sv
`timescale 1ns/1ns
`default_nettype none

`include "pu_spi_config.svh"

module byte_collector (
    input  logic      clk,
    input  logic      rst,
    spi_byte_if.sink  bus,
    spi_buf_if.writer rx
);

    localparam int DW    = `PU_DATA_WIDTH;
    localparam int SW    = `PU_SPI_DATA_WIDTH;
    localparam int BYTES = DW / SW;
    localparam int CNT_W = $clog2(BYTES);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(BYTES - 1);

    logic [CNT_W-1:0] cnt;
    // Only the leading bytes are held, the last one comes straight off the bus
    logic [DW-SW-1:0] partial;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (bus.start) begin
            cnt <= '0;
        end else if (bus.ready) begin
            cnt <= (cnt == LAST_CNT) ? '0 : cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.ready) begin
            partial <= {partial[DW-2*SW-1:0], bus.rx_byte};
        end
    end

    assign rx.wr    = bus.ready && (cnt == LAST_CNT);
    assign rx.wdata = {partial, bus.rx_byte};

endmodule

`default_nettype wire

//--- hdl/hoarder.sv
`timescale 1ns/1ns
`default_nettype none

`include "pu_spi_config.svh"

module hoarder
    import pu_spi_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    spi_byte_if.source                bus,
    input  logic [`PU_DATA_WIDTH-1:0] word,
    input  logic                      word_empty,
    output logic                      pop
);

    localparam int DW    = `PU_DATA_WIDTH;
    localparam int SW    = `PU_SPI_DATA_WIDTH;
    localparam int BYTES = DW / SW;
    localparam int IDX_W = $clog2(BYTES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(BYTES - 1);

    hoarder_state_e   state;
    logic [IDX_W-1:0] idx;
    logic [DW-1:0]    word_reg;
    logic             load;

    // Take the next word at frame start or once the last byte has gone out
    assign load = bus.start || (state == H_LOAD && bus.ready);
    assign pop  = load && !word_empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= H_IDLE;
            idx   <= '0;
        end else if (load) begin
            state <= H_SHIFT;
            idx   <= IDX_W'(1);
        end else if (state == H_SHIFT && bus.ready) begin
            if (idx == LAST_IDX) begin
                state <= H_LOAD;
                idx   <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // Empty drain bank sends zeros
    always_ff @(posedge clk) begin
        if (load) begin
            word_reg <= word_empty ? '0 : word;
        end
    end

    // Outside H_SHIFT the head word's MSB is already on offer
    always_comb begin
        if (state == H_SHIFT) begin
            bus.tx_byte = word_reg[(BYTES - 1 - int'(idx)) * SW +: SW];
        end else begin
            bus.tx_byte = word_empty ? '0 : word[DW-1 -: SW];
        end
    end

endmodule

`default_nettype wire

//--- hdl/pu_slave_spi.sv
`timescale 1ns/1ns
`default_nettype none

`include "pu_spi_config.svh"

module pu_slave_spi
    import pu_spi_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      signal_cycle,

    // System side
    input  logic                      signal_wr,
    input  logic [`PU_DATA_WIDTH-1:0] data_in,
    input  logic                      signal_oe,
    output logic [`PU_DATA_WIDTH-1:0] data_out,
    output logic [`PU_ATTR_WIDTH-1:0] attr_out,
    output logic                      flag_start,
    output logic                      flag_stop,

    // SPI pins
    input  logic                      mosi,
    output logic                      miso,
    input  logic                      sclk,
    input  logic                      cs
);

    spi_byte_if byte_bus ();
    spi_buf_if  bank_a_if ();
    spi_buf_if  bank_b_if ();
    spi_buf_if  rx_if ();

    logic [`PU_DATA_WIDTH-1:0] drain_word;
    logic                      drain_empty;
    logic                      drain_pop;
    logic                      finish;

    spi_slave_driver u_driver (
        .clk  (clk),
        .rst  (rst),
        .mosi (mosi),
        .sclk (sclk),
        .cs   (cs),
        .miso (miso),
        .bus  (byte_bus)
    );

    // Two ping-pong send banks and the receive FIFO
    spi_buffer #(.DEPTH(`PU_BUF_SIZE)) u_bank_a (.clk(clk), .rst(rst), .port(bank_a_if));
    spi_buffer #(.DEPTH(`PU_BUF_SIZE)) u_bank_b (.clk(clk), .rst(rst), .port(bank_b_if));
    spi_buffer #(.DEPTH(`PU_BUF_SIZE)) u_receive (.clk(clk), .rst(rst), .port(rx_if));

    hoarder u_hoarder (
        .clk        (clk),
        .rst        (rst),
        .bus        (byte_bus),
        .word       (drain_word),
        .word_empty (drain_empty),
        .pop        (drain_pop)
    );

    byte_collector u_collector (
        .clk (clk),
        .rst (rst),
        .bus (byte_bus),
        .rx  (rx_if)
    );

    // Each bank seen once as fill side and once as drain side
    spi_bank_control u_bank_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cs           (cs),
        .signal_cycle (signal_cycle),
        .signal_wr    (signal_wr),
        .signal_oe    (signal_oe),
        .data_in      (data_in),
        .bus_stop     (byte_bus.stop),
        .bank_a       (bank_a_if),
        .bank_b       (bank_b_if),
        .drain_a      (bank_a_if),
        .drain_b      (bank_b_if),
        .pop          (drain_pop),
        .word         (drain_word),
        .word_empty   (drain_empty),
        .finish       (finish)
    );

    assign rx_if.oe   = signal_oe;
    assign data_out   = rx_if.rdata;
    assign flag_start = byte_bus.start;
    assign flag_stop  = byte_bus.stop;

    always_comb begin
        attr_out             = rx_if.attr;
        attr_out[SPI_FINISH] = finish;
    end

endmodule

`default_nettype wire

//--- hdl/pu_spi_config.svh
`ifndef PU_SPI_CONFIG_SVH
`define PU_SPI_CONFIG_SVH

// System side word width
`define PU_DATA_WIDTH 32

// One SPI transfer unit
`define PU_SPI_DATA_WIDTH 8

// Attribute vector, one bit per attr_bit_e entry
`define PU_ATTR_WIDTH 4

// Words held by each buffer
`define PU_BUF_SIZE 6

`endif

//--- hdl/pu_spi_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "pu_spi_config.svh"

// Byte stream between the pin driver and the word side
interface spi_byte_if;
    logic [`PU_SPI_DATA_WIDTH-1:0] tx_byte;
    logic [`PU_SPI_DATA_WIDTH-1:0] rx_byte;
    logic                          ready;
    logic                          start;
    // End of transaction, one cycle
    logic                          stop;

    modport driver (input tx_byte, output rx_byte, output ready, output start, output stop);
    modport source (output tx_byte, input ready, input start);
    modport sink   (input rx_byte, input ready, input start);
endinterface

// Word FIFO access, writer side and reader side
interface spi_buf_if;
    logic                      wr;
    logic [`PU_DATA_WIDTH-1:0] wdata;
    logic                      oe;
    logic [`PU_DATA_WIDTH-1:0] rdata;
    logic [`PU_ATTR_WIDTH-1:0] attr;

    modport writer (output wr, output wdata, input attr);
    modport reader (output oe, input rdata, input attr);
    modport buffer (
        input  wr,
        input  wdata,
        input  oe,
        output rdata,
        output attr
    );
endinterface

`default_nettype wire

//--- hdl/pu_spi_pkg.sv
`default_nettype none

package pu_spi_pkg;

    // Bit positions inside an attribute vector
    typedef enum logic [1:0] {
        INVALID    = 2'd0,
        VALID      = 2'd1,
        SPI_FINISH = 2'd2,
        FULL       = 2'd3
    } attr_bit_e;

    // Send bank currently filled by the system
    typedef enum logic {
        BANK_A = 1'b0,
        BANK_B = 1'b1
    } bank_e;

    // Word-to-byte serializer
    typedef enum logic [1:0] {
        H_IDLE,
        H_LOAD,
        H_SHIFT
    } hoarder_state_e;

endpackage

`default_nettype wire

//--- hdl/spi_bank_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "pu_spi_config.svh"

module spi_bank_control
    import pu_spi_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cs,
    input  logic                      signal_cycle,
    input  logic                      signal_wr,
    input  logic                      signal_oe,
    input  logic [`PU_DATA_WIDTH-1:0] data_in,
    input  logic                      bus_stop,
    spi_buf_if.writer                 bank_a,
    spi_buf_if.writer                 bank_b,
    spi_buf_if.reader                 drain_a,
    spi_buf_if.reader                 drain_b,
    input  logic                      pop,
    output logic [`PU_DATA_WIDTH-1:0] word,
    output logic                      word_empty,
    output logic                      finish
);

    bank_e      bank_sel;
    logic [1:0] cs_sync;
    logic       fill_has_data;
    logic       swap;

    // ------------------------------------------------------------------------
    // Bank swap, only between transactions
    // ------------------------------------------------------------------------
    assign fill_has_data = (bank_sel == BANK_A) ? !bank_a.attr[INVALID]
                                                : !bank_b.attr[INVALID];
    assign swap = signal_cycle && cs_sync[1] && fill_has_data && word_empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs_sync  <= '1;
            bank_sel <= BANK_A;
            finish   <= 1'b0;
        end else begin
            cs_sync <= {cs_sync[0], cs};
            if (swap) begin
                bank_sel <= (bank_sel == BANK_A) ? BANK_B : BANK_A;
            end
            // Stop wins over a read in the same cycle
            if (bus_stop) begin
                finish <= 1'b1;
            end else if (signal_oe) begin
                finish <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Strobe steering and drain mux
    // ------------------------------------------------------------------------
    assign bank_a.wr    = signal_wr && (bank_sel == BANK_A);
    assign bank_a.wdata = data_in;
    assign bank_b.wr    = signal_wr && (bank_sel == BANK_B);
    assign bank_b.wdata = data_in;

    assign drain_a.oe = pop && (bank_sel == BANK_B);
    assign drain_b.oe = pop && (bank_sel == BANK_A);

    assign word       = (bank_sel == BANK_A) ? drain_b.rdata : drain_a.rdata;
    assign word_empty = (bank_sel == BANK_A) ? drain_b.attr[INVALID] : drain_a.attr[INVALID];

    // Drain bank pops only while cs is low
    a_pop_in_frame: assert property (@(posedge clk) disable iff (rst)
        pop |-> !cs_sync[1]);

endmodule

`default_nettype wire

//--- hdl/spi_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "pu_spi_config.svh"

module spi_buffer
    import pu_spi_pkg::*;
#(
    parameter int DEPTH = `PU_BUF_SIZE
) (
    input  logic      clk,
    input  logic      rst,
    spi_buf_if.buffer port
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] MAX_CNT  = CNT_W'(DEPTH);

    logic [`PU_DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]          count;
    logic                      push;
    logic                      pop;

    // Full drops writes, empty ignores reads
    assign push = port.wr && (count != MAX_CNT);
    assign pop  = port.oe && (count != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= port.wdata;
        end
    end

    assign port.rdata = mem[rd_ptr];

    // Flags straight from the fill level
    always_comb begin
        port.attr          = '0;
        port.attr[INVALID] = (count == '0);
        port.attr[VALID]   = (count != '0);
        port.attr[FULL]    = (count == MAX_CNT);
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst) count <= MAX_CNT);

endmodule

`default_nettype wire

//--- hdl/spi_slave_driver.sv
`timescale 1ns/1ns
`default_nettype none

`include "pu_spi_config.svh"

module spi_slave_driver (
    input  logic       clk,
    input  logic       rst,
    input  logic       mosi,
    input  logic       sclk,
    input  logic       cs,
    output logic       miso,
    spi_byte_if.driver bus
);

    localparam int SW    = `PU_SPI_DATA_WIDTH;
    localparam int CNT_W = $clog2(SW);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(SW - 1);

    logic [2:0]       sclk_sync;
    logic [2:0]       cs_sync;
    logic [1:0]       mosi_sync;
    logic [CNT_W-1:0] bit_cnt;
    logic [SW-1:0]    tx_shift;
    logic [SW-1:0]    rx_shift;
    logic             sclk_rise;
    logic             sclk_fall;
    logic             cs_fall;
    logic             cs_rise;
    logic             active;
    logic             byte_done;

    // Edges seen one flop past the synchronizer
    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign cs_fall   = ~cs_sync[1] & cs_sync[2];
    assign cs_rise   = cs_sync[1] & ~cs_sync[2];
    assign active    = ~cs_sync[1];
    assign byte_done = active & sclk_rise & (bit_cnt == LAST_BIT);

    assign miso = active & tx_shift[SW-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sclk_sync <= '0;
            cs_sync   <= '1;
            mosi_sync <= '0;
            bit_cnt   <= '0;
            tx_shift  <= '0;
            bus.start <= 1'b0;
            bus.stop  <= 1'b0;
            bus.ready <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[1:0], sclk};
            cs_sync   <= {cs_sync[1:0], cs};
            mosi_sync <= {mosi_sync[0], mosi};
            bus.start <= cs_fall;
            bus.stop  <= cs_rise;
            bus.ready <= byte_done;
            if (cs_fall) begin
                bit_cnt <= '0;
            end else if (active && sclk_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            // Falls at a byte boundary keep the freshly loaded MSB on miso
            if (bus.start || bus.ready) begin
                tx_shift <= bus.tx_byte;
            end else if (active && sclk_fall && bit_cnt != '0) begin
                tx_shift <= {tx_shift[SW-2:0], 1'b0};
            end
        end
    end

    // Mode 0 receive, mosi sampled on sclk rise
    always_ff @(posedge clk) begin
        if (active && sclk_rise) begin
            rx_shift <= {rx_shift[SW-2:0], mosi_sync[1]};
        end
        if (byte_done) begin
            bus.rx_byte <= {rx_shift[SW-2:0], mosi_sync[1]};
        end
    end

    // Master keeps cs low until the last bit of a byte has been taken
    a_ready_in_frame: assert property (@(posedge clk) disable iff (rst)
        bus.ready |-> !cs_sync[1]);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Compile and run the SPI slave testbench with Verilator
verilator --binary --assert -Wno-fatal --top-module tb_pu_slave_spi -f flist.f -o sim_tb \
    || { echo "run.sh: build failed"; exit 1; }
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
